// File: common/fixFloatPkg.sv
`default_nettype none

package fixFloatPkg;

    parameter int wordWidth = 64;

    // float32 field widths and bias
    parameter int expWidth = 8;
    parameter int fracWidth = 23;
    parameter int expBias = 127;

    // a bit position inside the input word, and the signed distance built from it
    parameter int posWidth = $clog2(wordWidth);
    parameter int distWidth = posWidth + 1;

    typedef struct packed {
        logic sign;
        logic [wordWidth-1:0] mag;
        logic isZero;
    } magT;

    typedef struct packed {
        logic sign;
        logic [wordWidth-1:0] mag;
        logic isZero;
        logic signed [distWidth-1:0] distance;
    } distT;

    // mant has its leading one at the top bit unless isZero
    typedef struct packed {
        logic sign;
        logic isZero;
        logic [expWidth-1:0] exponent;
        logic [wordWidth-1:0] mant;
    } normT;

endpackage

`default_nettype wire

// File: design/magnitudeStage.sv
`timescale 1ns/100ps
`default_nettype none

module magnitudeStage import fixFloatPkg::*; (
    input wire clk,
    input wire rstN,
    input wire [wordWidth-1:0] inWord,
    input wire inValid,
    output logic inReady,
    output magT outData,
    output logic outValid,
    input wire outReady
);

    magT nextData;
    logic negative;

    assign negative = inWord[wordWidth-1];

    // the most negative word negates to itself, which reads as 2^63 unsigned
    always_comb begin
        nextData.sign = negative;
        nextData.mag = negative ? (~inWord + 1'b1) : inWord;
        nextData.isZero = (inWord == '0);
    end

    // register empty or drained this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= nextData;
        end
    end

endmodule

`default_nettype wire

// File: normalize/leadDistance.sv
`timescale 1ns/100ps
`default_nettype none

module leadDistance import fixFloatPkg::*; #(
    parameter int fracBits = 27
) (
    input wire clk,
    input wire rstN,
    input magT inData,
    input wire inValid,
    output logic inReady,
    output distT outData,
    output logic outValid,
    input wire outReady
);

    logic [posWidth-1:0] leadPos;
    logic found;
    distT nextData;

    // priority chain from the top bit down, first set bit wins
    always_comb begin
        leadPos = '0;
        found = 1'b0;
        for (int i = wordWidth - 1; i >= 0; i--) begin
            if (!found && inData.mag[i]) begin
                leadPos = posWidth'(i);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        nextData.sign = inData.sign;
        nextData.mag = inData.mag;
        nextData.isZero = inData.isZero;
        // positive above the binary point, negative below it
        if (inData.isZero) begin
            nextData.distance = '0;
        end else begin
            nextData.distance = distWidth'(leadPos) - distWidth'(fracBits);
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= nextData;
        end
    end

endmodule

`default_nettype wire

// File: normalize/normalizeShift.sv
`timescale 1ns/100ps
`default_nettype none

module normalizeShift import fixFloatPkg::*; #(
    parameter int fracBits = 27
) (
    input wire clk,
    input wire rstN,
    input distT inData,
    input wire inValid,
    output logic inReady,
    output normT outData,
    output logic outValid,
    input wire outReady
);

    logic [posWidth-1:0] shiftAmt;
    logic [expWidth-1:0] distExt;
    normT nextData;

    // leading one sits at fracBits + distance, move it to the top bit
    assign shiftAmt = posWidth'(wordWidth - 1 - fracBits) - posWidth'(inData.distance);

    assign distExt = {{(expWidth - distWidth){inData.distance[distWidth-1]}}, inData.distance};

    always_comb begin
        nextData.sign = inData.sign;
        nextData.isZero = inData.isZero;
        nextData.exponent = expWidth'(expBias) + distExt;
        nextData.mant = inData.mag << shiftAmt;
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= nextData;
        end
    end

endmodule

`default_nettype wire

// File: design/roundPack.sv
`timescale 1ns/100ps
`default_nettype none

module roundPack import fixFloatPkg::*; (
    input wire clk,
    input wire rstN,
    input normT inData,
    input wire inValid,
    output logic inReady,
    output logic [expWidth+fracWidth:0] outFloat,
    output logic outValid,
    input wire outReady
);

    // bit positions below the hidden one
    localparam int fracLsb = wordWidth - 1 - fracWidth;
    localparam int guardPos = fracLsb - 1;

    logic [fracWidth-1:0] fraction;
    logic guard;
    logic sticky;
    logic roundUp;
    logic [fracWidth:0] fracSum;
    logic [expWidth-1:0] expRounded;
    logic [expWidth+fracWidth:0] nextFloat;

    assign fraction = inData.mant[wordWidth-2 -: fracWidth];
    assign guard = inData.mant[guardPos];
    assign sticky = |inData.mant[guardPos-1:0];

    // nearest, ties go to the even fraction
    assign roundUp = guard && (sticky || fraction[0]);

    assign fracSum = {1'b0, fraction} + (fracWidth + 1)'(roundUp);

    // carry out leaves an all-zero fraction and bumps the exponent
    assign expRounded = inData.exponent + expWidth'(fracSum[fracWidth]);

    always_comb begin
        if (inData.isZero) begin
            nextFloat = '0;
        end else begin
            nextFloat = {inData.sign, expRounded, fracSum[fracWidth-1:0]};
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outFloat <= nextFloat;
        end
    end

endmodule

`default_nettype wire

// File: design/fixToFloat.sv
`timescale 1ns/100ps
`default_nettype none

module fixToFloat import fixFloatPkg::*; #(
    parameter int fracBits = 27
) (
    input wire clk,
    input wire rstN,
    input wire [wordWidth-1:0] inWord,
    input wire inValid,
    output logic inReady,
    output logic [31:0] outFloat,
    output logic outValid,
    input wire outReady
);

    magT magData;
    logic magValid;
    logic magReady;

    distT distData;
    logic distValid;
    logic distReady;

    normT normData;
    logic normValid;
    logic normReady;

    magnitudeStage magnitudeStage_i (
        .clk(clk),
        .rstN(rstN),
        .inWord(inWord),
        .inValid(inValid),
        .inReady(inReady),
        .outData(magData),
        .outValid(magValid),
        .outReady(magReady)
    );

    leadDistance #(.fracBits(fracBits)) leadDistance_i (
        .clk(clk),
        .rstN(rstN),
        .inData(magData),
        .inValid(magValid),
        .inReady(magReady),
        .outData(distData),
        .outValid(distValid),
        .outReady(distReady)
    );

    normalizeShift #(.fracBits(fracBits)) normalizeShift_i (
        .clk(clk),
        .rstN(rstN),
        .inData(distData),
        .inValid(distValid),
        .inReady(distReady),
        .outData(normData),
        .outValid(normValid),
        .outReady(normReady)
    );

    roundPack roundPack_i (
        .clk(clk),
        .rstN(rstN),
        .inData(normData),
        .inValid(normValid),
        .inReady(normReady),
        .outFloat(outFloat),
        .outValid(outValid),
        .outReady(outReady)
    );

endmodule

`default_nettype wire

// File: tb/fixToFloat_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fixToFloatChk import fixFloatPkg::*; (
    input wire clk,
    input wire rstN,
    input wire inValid,
    input wire inReady,
    input magT magData,
    input wire magValid,
    input wire [31:0] outFloat,
    input wire outValid,
    input wire outReady
);

    assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is held");

    assert property (@(posedge clk) $rose(rstN) |-> !outValid)
        else $error("outValid high on the first edge after reset");

    // a stalled output word holds until it is taken
    assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outFloat))
        else $error("output word changed or dropped while stalled");

    // a refused input must not enter the first stage register
    assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> $stable(magData) && $stable(magValid))
        else $error("input taken while inReady was low");

endmodule

bind fixToFloat fixToFloatChk fixToFloatChk_i (
    .clk(clk),
    .rstN(rstN),
    .inValid(inValid),
    .inReady(inReady),
    .magData(magData),
    .magValid(magValid),
    .outFloat(outFloat),
    .outValid(outValid),
    .outReady(outReady)
);

`default_nettype wire

// File: tb/fixToFloatTb.sv
`timescale 1ns/100ps
`default_nettype none

module fixToFloatTb;

    localparam int fracBits = 27;
    localparam int tableSize = 14;
    localparam int randCount = 200;
    localparam int timeoutCycles = (tableSize + 2 * randCount + 10) * 8;

    typedef struct packed {
        logic [63:0] word;
        logic [31:0] expected;
    } vecT;

    // Q36.27 inputs with hand-computed float32 bits
    localparam vecT vecTable [tableSize] = '{
        '{64'h0000_0000_0000_0000, 32'h0000_0000},
        '{64'h0000_0000_0800_0000, 32'h3F80_0000},
        '{64'hFFFF_FFFF_F800_0000, 32'hBF80_0000},
        '{64'h4000_0000_0000_0000, 32'h5100_0000},
        '{64'h0000_0000_0000_0001, 32'h3200_0000},
        '{64'h8000_0000_0000_0000, 32'hD180_0000},
        '{64'h0000_0000_0000_0003, 32'h32C0_0000},
        '{64'h0008_0000_0400_0000, 32'h4B80_0000},
        '{64'h0008_0000_0800_0001, 32'h4B80_0001},
        '{64'h0008_0000_0800_0000, 32'h4B80_0000},
        '{64'h0008_0000_1800_0000, 32'h4B80_0002},
        '{64'hFFF7_FFFF_F7FF_FFFF, 32'hCB80_0001},
        '{64'h000F_FFFF_F800_0000, 32'h4C00_0000},
        '{64'h7FFF_FFFF_FFFF_FFFF, 32'h5180_0000}
    };

    logic clk = 1'b0;
    logic rstN = 1'b1;
    logic [63:0] inWord = '0;
    logic inValid = 1'b0;
    logic inReady;
    logic [31:0] outFloat;
    logic outValid;
    logic outReady = 1'b1;
    logic [31:0] expWord = '0;
    logic bpMode = 1'b0;
    logic [31:0] lfsrState = 32'd75846;
    logic [31:0] readyState = 32'd75846;
    vecT sendQ [$];
    vecT expQ [$];
    int acceptQ [$];
    vecT randVec [randCount];
    int cycleCount = 0;
    int mainErrors = 0;
    int mainChecks = 0;
    int sbErrors = 0;
    int sbChecks = 0;
    int sentCount = 0;
    int recvCount = 0;

    fixToFloat #(.fracBits(fracBits)) fixToFloat_i (
        .clk(clk),
        .rstN(rstN),
        .inWord(inWord),
        .inValid(inValid),
        .inReady(inReady),
        .outFloat(outFloat),
        .outValid(outValid),
        .outReady(outReady)
    );

    always #2 clk = ~clk;

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // nearest float32 of a Q(63-fracBits).fracBits word with ties to even
    function automatic logic [31:0] refFloat(input logic [63:0] w);
        logic s;
        logic [63:0] m;
        logic [63:0] shifted;
        logic [63:0] rest;
        logic [63:0] half;
        logic [23:0] sig;
        logic [24:0] sum;
        logic rnd;
        int msb;
        int e;
        if (w == 64'd0) begin
            return 32'd0;
        end
        s = w[63];
        m = s ? -w : w;
        msb = 63;
        while (!m[msb]) begin
            msb--;
        end
        e = 127 + msb - fracBits;
        rnd = 1'b0;
        if (msb <= 23) begin
            shifted = m << (23 - msb);
        end else begin
            shifted = m >> (msb - 23);
            rest = m & ((64'd1 << (msb - 23)) - 64'd1);
            half = 64'd1 << (msb - 24);
            rnd = (rest > half) || (rest == half && shifted[0]);
        end
        sig = shifted[23:0];
        sum = {1'b0, sig} + 25'(rnd);
        if (sum[24]) begin
            e = e + 1;
            sum = sum >> 1;
        end
        return {s, e[7:0], sum[22:0]};
    endfunction

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // ready follows the LFSR only while back-pressure is on
    always @(posedge clk) begin
        if (bpMode) begin
            outReady <= readyState[0];
            readyState <= lfsrNext(readyState);
        end else begin
            outReady <= 1'b1;
            readyState <= lfsrState;
        end
    end

    // the scoreboard samples at the falling edge where handshakes are settled
    always @(negedge clk) begin
        vecT front;
        int latency;
        if (rstN && inValid && !inReady && !bpMode) begin
            $display("inReady was low at %0t although outReady is held high", $time);
            sbErrors++;
        end
        if (rstN && inValid && inReady) begin
            expQ.push_back({inWord, expWord});
            acceptQ.push_back(cycleCount);
            sentCount++;
        end
        if (rstN && outValid && outReady) begin
            recvCount++;
            if (expQ.size() == 0) begin
                $display("output %h arrived with no input pending", outFloat);
                sbErrors++;
            end else begin
                front = expQ.pop_front();
                latency = cycleCount - acceptQ.pop_front();
                sbChecks++;
                if (outFloat !== front.expected) begin
                    $display("ERROR %0t: input %h expected %h got %h",
                             $time, front.word, front.expected, outFloat);
                    sbErrors++;
                end
                if (!bpMode && latency != 4) begin
                    $display("ERROR %0t: input %h took %0d cycles, expected 4",
                             $time, front.word, latency);
                    sbErrors++;
                end
            end
        end
    end

    task automatic runTest(input string name);
        int errBase;
        int sentBase;
        int recvBase;
        int words;
        vecT v;
        errBase = mainErrors + sbErrors;
        sentBase = sentCount;
        recvBase = recvCount;
        words = sendQ.size();
        @(posedge clk);
        while (sendQ.size() != 0) begin
            v = sendQ.pop_front();
            inWord <= v.word;
            expWord <= v.expected;
            inValid <= 1'b1;
            @(negedge clk);
            while (!inReady) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        inValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        mainChecks++;
        if (sentCount - sentBase != words || recvCount - recvBase != words) begin
            $display("test %s: sent %0d and received %0d of %0d words",
                     name, sentCount - sentBase, recvCount - recvBase, words);
            mainErrors++;
        end
        $display("test %s: %0d words, %0d errors", name, words, mainErrors + sbErrors - errBase);
    endtask

    initial begin
        logic [63:0] raw;
        logic [5:0] shiftBits;
        raw = '0;
        shiftBits = '0;
        #1;
        rstN <= 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        mainChecks++;
        if (outValid !== 1'b0 || inReady !== 1'b1) begin
            $display("ERROR %0t: after reset outValid %b inReady %b", $time, outValid, inReady);
            mainErrors++;
        end

        // the hand table also cross-checks the model
        for (int i = 0; i < tableSize; i++) begin
            mainChecks++;
            if (refFloat(vecTable[i].word) !== vecTable[i].expected) begin
                $display("ERROR %0t: model gives %h for input %h, table has %h", $time,
                         refFloat(vecTable[i].word), vecTable[i].word, vecTable[i].expected);
                mainErrors++;
            end
            sendQ.push_back(vecTable[i]);
        end
        runTest("table");

        // an arithmetic shift spreads the leading one of the random words over all positions
        for (int i = 0; i < randCount; i++) begin
            for (int b = 0; b < 64; b++) begin
                lfsrState = lfsrNext(lfsrState);
                raw = {raw[62:0], lfsrState[0]};
            end
            for (int b = 0; b < 6; b++) begin
                lfsrState = lfsrNext(lfsrState);
                shiftBits = {shiftBits[4:0], lfsrState[0]};
            end
            randVec[i].word = $signed(raw) >>> shiftBits;
            randVec[i].expected = refFloat(randVec[i].word);
            sendQ.push_back(randVec[i]);
        end
        runTest("random");

        bpMode = 1'b1;
        for (int i = 0; i < randCount; i++) begin
            sendQ.push_back(randVec[i]);
        end
        runTest("backpressure");
        bpMode = 1'b0;

        $display("summary: %0d checks, %0d errors", mainChecks + sbChecks, mainErrors + sbErrors);
        if (mainErrors + sbErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: the pipeline did not finish within %0d cycles", timeoutCycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/fixFloatPkg.sv
design/magnitudeStage.sv
normalize/leadDistance.sv
normalize/normalizeShift.sv
design/roundPack.sv
design/fixToFloat.sv
tb/fixToFloat_chk.sv
tb/fixToFloatTb.sv

// File: Makefile
VERILATOR = verilator
TOP = fixToFloatTb
FILELIST = sim.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Checks failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
